// ==== verilog/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  // ======================================================================
  // address and data geometry
  // ======================================================================

  // byte address width
  localparam int ADDR_W = 32;

  // fetch word and bus data width
  localparam int WORD_W = 32;

  // one line is four words, 16 bytes
  localparam int LINE_WORDS = 4;
  localparam int WOFS_W     = 2;

  // byte offset inside a word
  localparam int BYTE_W = 2;

  // ======================================================================
  // associativity
  // ======================================================================

  localparam int WAY_NUM = 4;
  localparam int WAY_W   = 2;

  // ======================================================================
  // controller states
  // ======================================================================

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    REFILL
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== verilog/icache_refill.sv ====
`default_nettype none

module icache_refill (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          start_i,
  input  logic [icache_pkg::ADDR_W-1:0] line_adr_i,
  input  logic [icache_pkg::WORD_W-1:0] wb_dat_i,
  input  logic                          wb_ack_i,
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output logic                          wb_we_o,
  output logic [icache_pkg::ADDR_W-1:0] wb_adr_o,
  output logic                          beat_we_o,
  output logic [icache_pkg::WOFS_W-1:0] beat_ofs_o,
  output logic [icache_pkg::WORD_W-1:0] beat_data_o,
  output logic                          done_o
);
  import icache_pkg::*;

  logic [WOFS_W-1:0] beat_q;
  logic              cyc_q;
  logic              stb_q;
  logic              done_q;
  logic              last_beat;

  assign last_beat = (beat_q == WOFS_W'(LINE_WORDS - 1));

  // every ack lands one word in the arrays
  assign beat_we_o   = stb_q & wb_ack_i;
  assign beat_ofs_o  = beat_q;
  assign beat_data_o = wb_dat_i;

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      cyc_q  <= 1'b0;
      stb_q  <= 1'b0;
      done_q <= 1'b0;
      beat_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        cyc_q  <= 1'b1;
        stb_q  <= 1'b1;
        beat_q <= '0;
      end else if (beat_we_o) begin
        stb_q <= 1'b0;
        if (last_beat) begin
          cyc_q  <= 1'b0;
          done_q <= 1'b1;
        end else begin
          beat_q <= beat_q + 1'b1;
        end
      end else if (cyc_q && !stb_q) begin
        // one idle cycle between beats
        stb_q <= 1'b1;
      end
    end
  end

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = stb_q;
  assign wb_we_o  = 1'b0;
  assign wb_adr_o = {line_adr_i[ADDR_W-1:WOFS_W+BYTE_W], beat_q, {BYTE_W{1'b0}}};
  assign done_o   = done_q;

  assert property (@(posedge clk_i) disable iff (!rst_i)
    wb_stb_o |-> wb_cyc_o);

endmodule

`default_nettype wire

// ==== verilog/icache_ways.sv ====
`default_nettype none

module icache_ways #(
  parameter int SET_W = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           rd_en_i,
  input  logic [icache_pkg::ADDR_W-1:0]  addr_i,
  input  logic                           flush_i,
  input  logic                           tag_wr_i,
  input  logic [icache_pkg::WAY_W-1:0]   victim_way_i,
  input  logic                           beat_we_i,
  input  logic [icache_pkg::WOFS_W-1:0]  beat_ofs_i,
  input  logic [icache_pkg::WORD_W-1:0]  beat_data_i,
  output logic                           hit_o,
  output logic [icache_pkg::WAY_W-1:0]   hit_way_o,
  output logic [icache_pkg::WAY_NUM-1:0] way_valid_o,
  output logic [icache_pkg::WORD_W-1:0]  data_o
);
  import icache_pkg::*;

  localparam int TAG_W = ADDR_W - SET_W - WOFS_W - BYTE_W;
  localparam int SETS  = 1 << SET_W;

  // ======================================================================
  // storage
  // ======================================================================
  logic [TAG_W-1:0]             tag_mem  [WAY_NUM][SETS];
  logic [WORD_W-1:0]            data_mem [WAY_NUM][SETS*LINE_WORDS];
  logic [WAY_NUM-1:0][SETS-1:0] valid_q;

  logic                         rd_q;
  logic [TAG_W-1:0]             addr_tag;
  logic [SET_W-1:0]             addr_set;
  logic [WOFS_W-1:0]            addr_wofs;
  logic [WAY_NUM-1:0]           set_valid;
  logic [WAY_NUM-1:0]           hit_vec;
  logic [WAY_W-1:0]             hit_way;

  // fields of the latched address
  assign addr_tag  = addr_i[ADDR_W-1 -: TAG_W];
  assign addr_set  = addr_i[WOFS_W+BYTE_W +: SET_W];
  assign addr_wofs = addr_i[BYTE_W +: WOFS_W];

  // refill beats and tag install both target the victim way
  always_ff @(posedge clk_i) begin
    if (beat_we_i) begin
      data_mem[victim_way_i][{addr_set, beat_ofs_i}] <= beat_data_i;
    end
    if (tag_wr_i) begin
      tag_mem[victim_way_i][addr_set] <= addr_tag;
    end
  end

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      valid_q <= '0;
      rd_q    <= 1'b0;
    end else begin
      rd_q <= rd_en_i;
      if (flush_i) begin
        valid_q <= '0;
      end else if (tag_wr_i) begin
        valid_q[victim_way_i][addr_set] <= 1'b1;
      end
    end
  end

  // ======================================================================
  // tag compare, one cycle after the read strobe
  // ======================================================================
  always_comb begin
    for (int w = 0; w < WAY_NUM; w++) begin
      set_valid[w] = valid_q[w][addr_set];
      hit_vec[w]   = set_valid[w] && (tag_mem[w][addr_set] == addr_tag);
    end
  end

  // one-hot to index
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < WAY_NUM; w++) begin
      if (hit_vec[w]) begin
        hit_way = WAY_W'(w);
      end
    end
  end

  assign hit_o       = rd_q & (|hit_vec);
  assign hit_way_o   = hit_way;
  assign way_valid_o = set_valid;
  assign data_o      = data_mem[hit_way][{addr_set, addr_wofs}];

  // a line is never present in two ways of one set
  assert property (@(posedge clk_i) disable iff (!rst_i)
    rd_q |-> $onehot0(hit_vec));

endmodule

`default_nettype wire

// ==== verilog/icache_plru.sv ====
`default_nettype none

module icache_plru #(
  parameter int SET_W = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic [SET_W-1:0]               set_i,
  input  logic                           hit_i,
  input  logic [icache_pkg::WAY_W-1:0]   hit_way_i,
  input  logic [icache_pkg::WAY_NUM-1:0] way_valid_i,
  output logic [icache_pkg::WAY_W-1:0]   victim_way_o
);
  import icache_pkg::*;

  localparam int SETS = 1 << SET_W;

  // root bit and two leaf bits per set
  logic [SETS-1:0]      b0_q;
  logic [SETS-1:0][1:0] b1_q;
  logic [WAY_W-1:0]     inv_way;
  logic [WAY_W-1:0]     plru_way;
  logic                 all_valid;

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      b0_q <= '0;
      b1_q <= '0;
    end else if (hit_i) begin
      b0_q[set_i]               <= hit_way_i[0];
      b1_q[set_i][hit_way_i[0]] <= hit_way_i[1];
    end
  end

  // lowest numbered empty way
  always_comb begin
    inv_way = '0;
    for (int w = WAY_NUM - 1; w >= 0; w--) begin
      if (!way_valid_i[w]) begin
        inv_way = WAY_W'(w);
      end
    end
  end

  // walk away from the recently used half
  assign plru_way[0] = ~b0_q[set_i];
  assign plru_way[1] = ~b1_q[set_i][plru_way[0]];

  assign all_valid    = &way_valid_i;
  assign victim_way_o = all_valid ? plru_way : inv_way;

endmodule

`default_nettype wire

// ==== verilog/icache_ctrl.sv ====
`default_nettype none

module icache_ctrl #(
  parameter int SET_W = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          req_i,
  input  logic [icache_pkg::ADDR_W-1:0] addr_i,
  input  logic                          flush_i,
  input  logic                          hit_i,
  input  logic                          refill_done_i,
  output logic                          ready_o,
  output logic                          valid_o,
  output logic                          flush_done_o,
  output logic                          cache_miss_o,
  output logic                          rd_en_o,
  output logic                          flush_o,
  output logic                          refill_start_o,
  output logic                          tag_wr_o,
  output logic [icache_pkg::ADDR_W-1:0] addr_q_o
);
  import icache_pkg::*;

  ctrl_state_e       state_q;
  ctrl_state_e       state_d;
  logic [ADDR_W-1:0] addr_q;

  // ======================================================================
  // next state and strobes
  // ======================================================================
  always_comb begin
    state_d        = state_q;
    ready_o        = 1'b0;
    valid_o        = 1'b0;
    flush_done_o   = 1'b0;
    cache_miss_o   = 1'b0;
    rd_en_o        = 1'b0;
    refill_start_o = 1'b0;
    tag_wr_o       = 1'b0;
    unique case (state_q)
      IDLE: begin
        // flush takes the cycle, no request accepted
        if (flush_i) begin
          flush_done_o = 1'b1;
        end else begin
          ready_o = 1'b1;
          if (req_i) begin
            rd_en_o = 1'b1;
            state_d = LOOKUP;
          end
        end
      end
      LOOKUP: begin
        if (hit_i) begin
          valid_o = 1'b1;
          // next request may enter while this one answers
          ready_o = 1'b1;
          if (req_i) begin
            rd_en_o = 1'b1;
          end else begin
            state_d = IDLE;
          end
        end else begin
          cache_miss_o   = 1'b1;
          refill_start_o = 1'b1;
          state_d        = REFILL;
        end
      end
      REFILL: begin
        // line complete, install tag and look up again
        if (refill_done_i) begin
          tag_wr_o = 1'b1;
          rd_en_o  = 1'b1;
          state_d  = LOOKUP;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign flush_o  = flush_done_o;
  assign addr_q_o = addr_q;

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // address of the access in flight
  always_ff @(posedge clk_i) begin
    if (req_i && ready_o) begin
      addr_q <= addr_i;
    end
  end

  // ======================================================================
  // checks
  // ======================================================================
  assert property (@(posedge clk_i) disable iff (!rst_i)
    valid_o |-> (state_q == LOOKUP));

  // done only arrives while a line is being fetched
  assert property (@(posedge clk_i) disable iff (!rst_i)
    refill_done_i |-> (state_q == REFILL));

endmodule

`default_nettype wire

// ==== verilog/icache_top.sv ====
`default_nettype none

module icache_top #(
  parameter int SET_W = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          req_i,
  input  logic [icache_pkg::ADDR_W-1:0] addr_i,
  output logic                          ready_o,
  output logic                          valid_o,
  output logic [icache_pkg::WORD_W-1:0] data_o,
  input  logic                          flush_i,
  output logic                          flush_done_o,
  output logic                          cache_miss_o,
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output logic                          wb_we_o,
  output logic [icache_pkg::ADDR_W-1:0] wb_adr_o,
  input  logic [icache_pkg::WORD_W-1:0] wb_dat_i,
  input  logic                          wb_ack_i
);
  import icache_pkg::*;

  logic               rd_en;
  logic               flush;
  logic               refill_start;
  logic               refill_done;
  logic               tag_wr;
  logic               hit;
  logic               beat_we;
  logic [ADDR_W-1:0]  addr_q;
  logic [WAY_W-1:0]   hit_way;
  logic [WAY_W-1:0]   victim_way;
  logic [WAY_NUM-1:0] way_valid;
  logic [WOFS_W-1:0]  beat_ofs;
  logic [WORD_W-1:0]  beat_data;

  icache_ctrl #(
    .SET_W(SET_W)
  ) u_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_i          (req_i),
    .addr_i         (addr_i),
    .flush_i        (flush_i),
    .hit_i          (hit),
    .refill_done_i  (refill_done),
    .ready_o        (ready_o),
    .valid_o        (valid_o),
    .flush_done_o   (flush_done_o),
    .cache_miss_o   (cache_miss_o),
    .rd_en_o        (rd_en),
    .flush_o        (flush),
    .refill_start_o (refill_start),
    .tag_wr_o       (tag_wr),
    .addr_q_o       (addr_q)
  );

  // wishbone side
  icache_refill u_refill (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .start_i     (refill_start),
    .line_adr_i  (addr_q),
    .wb_dat_i    (wb_dat_i),
    .wb_ack_i    (wb_ack_i),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_we_o     (wb_we_o),
    .wb_adr_o    (wb_adr_o),
    .beat_we_o   (beat_we),
    .beat_ofs_o  (beat_ofs),
    .beat_data_o (beat_data),
    .done_o      (refill_done)
  );

  icache_ways #(
    .SET_W(SET_W)
  ) u_ways (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rd_en_i      (rd_en),
    .addr_i       (addr_q),
    .flush_i      (flush),
    .tag_wr_i     (tag_wr),
    .victim_way_i (victim_way),
    .beat_we_i    (beat_we),
    .beat_ofs_i   (beat_ofs),
    .beat_data_i  (beat_data),
    .hit_o        (hit),
    .hit_way_o    (hit_way),
    .way_valid_o  (way_valid),
    .data_o       (data_o)
  );

  // replacement follows the set of the latched address
  icache_plru #(
    .SET_W(SET_W)
  ) u_plru (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .set_i        (addr_q[WOFS_W+BYTE_W +: SET_W]),
    .hit_i        (hit),
    .hit_way_i    (hit_way),
    .way_valid_i  (way_valid),
    .victim_way_o (victim_way)
  );

endmodule

`default_nettype wire

// ==== bench/tb_clkgen.sv ====
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // active low reset, released on a falling edge
  initial begin
    rst_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== bench/tb_icache.sv ====
`default_nettype none

module tb_icache;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          SET_W   = 4;
  localparam int          SETS    = 1 << SET_W;
  localparam int          TAG_W   = 32 - SET_W - 4;
  localparam int          LIMIT   = 200;
  localparam int          SETTLE  = 10;
  localparam logic [31:0] MEM_KEY = 32'h5a3c_96e1;
  localparam logic [31:0] SEED    = 32'h4e25;

  localparam int OP_FETCH = 0;
  localparam int OP_CHAIN = 1;
  localparam int OP_FLUSH = 2;

  typedef struct {
    int          op;
    logic [31:0] addr;
    logic        miss;
    logic [1:0]  way;
  } entry_t;

  logic        clk;
  logic        rst;
  logic        req;
  logic [31:0] addr;
  logic        ready;
  logic        valid;
  logic [31:0] data;
  logic        flush;
  logic        flush_done;
  logic        miss_pulse;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat;
  logic        wb_ack;

  entry_t stim_q[$];

  // reference copy of valid, tag and tree state
  logic [TAG_W-1:0] m_tag   [SETS][4];
  logic             m_valid [SETS][4];
  logic             m_b0    [SETS];
  logic [1:0]       m_b1    [SETS];

  tb_clkgen #(
    .PERIOD_NS  (100),
    .RST_CYCLES (2)
  ) u_clkgen (
    .clk_o (clk),
    .rst_o (rst)
  );

  icache_top #(
    .SET_W(SET_W)
  ) dut0 (
    .clk_i        (clk),
    .rst_i        (rst),
    .req_i        (req),
    .addr_i       (addr),
    .ready_o      (ready),
    .valid_o      (valid),
    .data_o       (data),
    .flush_i      (flush),
    .flush_done_o (flush_done),
    .cache_miss_o (miss_pulse),
    .wb_cyc_o     (wb_cyc),
    .wb_stb_o     (wb_stb),
    .wb_we_o      (wb_we),
    .wb_adr_o     (wb_adr),
    .wb_dat_i     (wb_dat),
    .wb_ack_i     (wb_ack)
  );

  // ======================================================================
  // helpers
  // ======================================================================
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return {2'b00, a[31:2]} ^ MEM_KEY;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    string msg;
    if (got !== exp) begin
      msg = $sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      fail_run(msg);
    end
  endtask

  task automatic add_entry(input int op, input logic [31:0] a, input logic m,
                           input logic [1:0] w);
    entry_t e;
    e.op   = op;
    e.addr = a;
    e.miss = m;
    e.way  = w;
    stim_q.push_back(e);
  endtask

  // invalid ways first, then away from the recently used half
  task automatic model_access(input logic [31:0] a, output logic miss, output logic [1:0] way);
    int               s;
    logic [TAG_W-1:0] t;
    logic             found_inv;
    s    = a[4 +: SET_W];
    t    = a[31 -: TAG_W];
    miss = 1'b1;
    way  = 2'd0;
    for (int w = 0; w < 4; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == t) begin
        miss = 1'b0;
        way  = 2'(w);
      end
    end
    if (miss) begin
      found_inv = 1'b0;
      for (int w = 3; w >= 0; w--) begin
        if (!m_valid[s][w]) begin
          found_inv = 1'b1;
          way       = 2'(w);
        end
      end
      if (!found_inv) begin
        way[0] = ~m_b0[s];
        way[1] = ~m_b1[s][way[0]];
      end
      m_valid[s][way] = 1'b1;
      m_tag[s][way]   = t;
    end
    m_b0[s]         = way[0];
    m_b1[s][way[0]] = way[1];
  endtask

  task automatic request_fetch(input logic [31:0] a);
    int n;
    n = 0;
    @(negedge clk);
    while (!ready) begin
      n++;
      if (n > LIMIT) fail_run("timeout while waiting for ready_o");
      @(negedge clk);
    end
    req  = 1'b1;
    addr = a;
    @(posedge clk);
  endtask

  // wait for the answer, then hand over the next chained address
  task automatic finish_fetch(input int idx);
    int         n;
    logic       saw_miss;
    logic       exp_miss;
    logic [1:0] exp_way;
    entry_t     e;
    e = stim_q[idx];
    model_access(e.addr, exp_miss, exp_way);
    check_val("table miss flag", e.miss, exp_miss);
    check_val("table way", e.way, exp_way);
    saw_miss = 1'b0;
    n        = 0;
    @(negedge clk);
    while (!valid) begin
      if (miss_pulse) saw_miss = 1'b1;
      n++;
      if (n > LIMIT) fail_run("timeout while waiting for valid_o");
      @(negedge clk);
    end
    check_val("data_o", data, mem_word(e.addr));
    check_val("cache_miss_o", saw_miss, exp_miss);
    check_val("hit_way", dut0.hit_way, exp_way);
    // a hit answers in the cycle right after acceptance
    if (!exp_miss) check_val("valid_o delay", n, 0);
    if (e.op == OP_CHAIN) begin
      req  = 1'b1;
      addr = stim_q[idx + 1].addr;
    end else begin
      req = 1'b0;
    end
  endtask

  task automatic do_flush();
    int n;
    n = 0;
    @(negedge clk);
    flush = 1'b1;
    #SETTLE;
    while (!flush_done) begin
      n++;
      if (n > LIMIT) fail_run("timeout while waiting for flush_done_o");
      @(negedge clk);
      #SETTLE;
    end
    check_val("ready_o", ready, 1'b0);
    @(negedge clk);
    flush = 1'b0;
    for (int s = 0; s < SETS; s++) begin
      for (int w = 0; w < 4; w++) begin
        m_valid[s][w] = 1'b0;
      end
    end
  endtask

  // ======================================================================
  // wishbone slave with random ack delay
  // ======================================================================
  initial begin
    int delay;
    int beat;
    wb_ack = 1'b0;
    wb_dat = '0;
    beat   = 0;
    delay  = $urandom(SEED) % 4;
    forever begin
      @(negedge clk);
      if (wb_ack) begin
        // strobe drops for one cycle after each ack
        check_val("wb_stb_o", wb_stb, 1'b0);
        wb_ack = 1'b0;
      end else if (wb_cyc && wb_stb) begin
        check_val("wb_we_o", wb_we, 1'b0);
        // line of the missed fetch, words in order
        check_val("wb_adr_o", wb_adr, {addr[31:4], 2'(beat), 2'b00});
        if (delay == 0) begin
          wb_ack = 1'b1;
          wb_dat = mem_word(wb_adr);
          beat   = (beat + 1) % 4;
          delay  = $urandom_range(3, 0);
        end else begin
          delay--;
        end
      end
    end
  end

  // ======================================================================
  // stimulus table and main sequence
  // ======================================================================
  task automatic build_table();
    // first touch, same line, then fill set 3
    add_entry(OP_FETCH, 32'h0000_1034, 1'b1, 2'd0);
    add_entry(OP_FETCH, 32'h0000_1038, 1'b0, 2'd0);
    add_entry(OP_FETCH, 32'h0000_2030, 1'b1, 2'd1);
    add_entry(OP_FETCH, 32'h0000_3030, 1'b1, 2'd2);
    add_entry(OP_FETCH, 32'h0000_403c, 1'b1, 2'd3);
    add_entry(OP_FETCH, 32'h0000_4030, 1'b0, 2'd3);
    add_entry(OP_FETCH, 32'h0000_1030, 1'b0, 2'd0);
    add_entry(OP_FETCH, 32'h0000_3034, 1'b0, 2'd2);
    add_entry(OP_FETCH, 32'h0000_2038, 1'b0, 2'd1);
    // fifth tag evicts the pseudo-LRU way
    add_entry(OP_FETCH, 32'habcd_5034, 1'b1, 2'd0);
    add_entry(OP_CHAIN, 32'h0000_2030, 1'b0, 2'd1);
    add_entry(OP_CHAIN, 32'h0000_3034, 1'b0, 2'd2);
    add_entry(OP_FETCH, 32'h0000_4038, 1'b0, 2'd3);
    add_entry(OP_FETCH, 32'h0000_103c, 1'b1, 2'd0);
    // back to back through a whole line of set 4
    add_entry(OP_CHAIN, 32'h0000_1040, 1'b1, 2'd0);
    add_entry(OP_CHAIN, 32'h0000_1044, 1'b0, 2'd0);
    add_entry(OP_CHAIN, 32'h0000_1048, 1'b0, 2'd0);
    add_entry(OP_FETCH, 32'h0000_104c, 1'b0, 2'd0);
    add_entry(OP_FLUSH, 32'h0000_0000, 1'b0, 2'd0);
    add_entry(OP_FETCH, 32'h0000_2030, 1'b1, 2'd0);
    add_entry(OP_FETCH, 32'h0000_103c, 1'b1, 2'd1);
    add_entry(OP_FETCH, 32'h0000_1040, 1'b1, 2'd0);
    add_entry(OP_CHAIN, 32'h0000_2034, 1'b0, 2'd0);
    add_entry(OP_FETCH, 32'h0000_1034, 1'b0, 2'd1);
  endtask

  initial begin
    int   n;
    logic chained;
    req     = 1'b0;
    addr    = '0;
    flush   = 1'b0;
    chained = 1'b0;
    n       = 0;
    for (int s = 0; s < SETS; s++) begin
      m_b0[s] = 1'b0;
      m_b1[s] = 2'b00;
      for (int w = 0; w < 4; w++) begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w]   = '0;
      end
    end
    build_table();
    while (rst !== 1'b1) begin
      n++;
      if (n > LIMIT) fail_run("timeout while waiting for reset release");
      @(negedge clk);
    end
    @(negedge clk);
    check_val("valid_o", valid, 1'b0);
    check_val("flush_done_o", flush_done, 1'b0);
    check_val("cache_miss_o", miss_pulse, 1'b0);
    check_val("wb_cyc_o", wb_cyc, 1'b0);
    check_val("wb_stb_o", wb_stb, 1'b0);
    for (int i = 0; i < stim_q.size(); i++) begin
      if (stim_q[i].op == OP_FLUSH) begin
        do_flush();
      end else begin
        if (!chained) request_fetch(stim_q[i].addr);
        finish_fetch(i);
        chained = (stim_q[i].op == OP_CHAIN);
      end
    end
    @(negedge clk);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/icache_pkg.sv
verilog/icache_refill.sv
verilog/icache_ways.sv
verilog/icache_plru.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
bench/tb_clkgen.sv
bench/tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - verilog/icache_pkg.sv
  - verilog/icache_refill.sv
  - verilog/icache_ways.sv
  - verilog/icache_plru.sv
  - verilog/icache_ctrl.sv
  - verilog/icache_top.sv
  - target: test
    files:
      - bench/tb_clkgen.sv
      - bench/tb_icache.sv
